/* build.f */
+incdir+dv
common/gba_loader_pkg.sv
rtl/download_decode.sv
rtl/bios_word_packer.sv
cart_scan/cart_signature_scan.sv
cart_scan/cart_quirk_match.sv
rtl/save_size_tracker.sv
rtl/gba_loader_top.sv
dv/gba_loader_tb.sv

/* Bender.yml */
package:
  name: gba_loader

sources:
  - common/gba_loader_pkg.sv
  - rtl/download_decode.sv
  - rtl/bios_word_packer.sv
  - cart_scan/cart_signature_scan.sv
  - cart_scan/cart_quirk_match.sv
  - rtl/save_size_tracker.sv
  - rtl/gba_loader_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/gba_loader_tb.sv

/* dv/gba_loader_ref.svh */
// Loader reference model with expected flags, sizes and BIOS words plus typed compare tasks
`ifndef GBA_LOADER_REF_SVH
`define GBA_LOADER_REF_SVH

localparam int IMG_BYTES  = 256;   // Largest cartridge image
localparam int TITLE_BASE = 'hA0;  // Header title, first byte

logic [7:0] cart_img [IMG_BYTES];  // Image bytes in stream order
int err_count   = 0;
int check_count = 0;

// ======================================================================
// Reference model
// ======================================================================
// Marker anywhere inside the bytes that were sent
function automatic logic expect_flash(input int nbytes);
	logic [71:0] window;
	logic        hit;
	hit = 1'b0;
	for (int s = 0; s + 9 <= nbytes; s++) begin
		window = '0;
		for (int j = 0; j < 9; j++) begin
			window = {window[63:0], cart_img[s + j]};
		end
		if (window == gba_loader_pkg::FLASH_SIG) hit = 1'b1;
	end
	return hit;
endfunction

function automatic logic expect_quirk();
	gba_loader_pkg::cart_id_t title;
	logic                     hit;
	title = '0;
	hit   = 1'b0;
	for (int j = 0; j < 12; j++) begin
		title = {title[87:0], cart_img[TITLE_BASE + j]};  // First character ends on top
	end
	for (int k = 0; k < gba_loader_pkg::QUIRK_COUNT; k++) begin
		if (title == gba_loader_pkg::QUIRK_IDS[k]) hit = 1'b1;
	end
	return hit;
endfunction

// Every reported save type widens the size
function automatic gba_loader_pkg::save_sz_t grown_size(input gba_loader_pkg::save_sz_t sz,
	input logic ee, input logic sr, input logic fl, input logic big_flash);
	if (ee) sz = sz | 8'h0F;                           // 8 KB EEPROM
	if (sr) sz = sz | 8'h3F;                           // 32 KB SRAM
	if (fl) sz = sz | (big_flash ? 8'hFF : 8'h7F);     // 128 or 64 KB flash
	return sz;
endfunction

function automatic gba_loader_pkg::save_sz_t mounted_size(
	input gba_loader_pkg::img_size_t size);
	return gba_loader_pkg::save_sz_t'(size / 512 - 1);  // 512-byte sectors minus one
endfunction

function automatic gba_loader_pkg::bios_word_t joined_word(input logic [15:0] lo,
	input logic [15:0] hi);
	return {hi, lo};  // Upper halfword lands in bits 31:16
endfunction

// ======================================================================
// Compare tasks
// ======================================================================
task automatic bios_check(input gba_loader_pkg::bios_addr_t exp_addr,
	input gba_loader_pkg::bios_word_t exp_word, input gba_loader_pkg::bios_addr_t act_addr,
	input gba_loader_pkg::bios_word_t act_word);
	check_count++;
	if (act_addr !== exp_addr || act_word !== exp_word) begin
		err_count++;
		$display("FAIL time %0t bios_wraddr expected %h actual %h", $time, exp_addr, act_addr);
		$display("FAIL time %0t bios_wrdata expected %h actual %h", $time, exp_word, act_word);
	end
endtask

task automatic size_check(input gba_loader_pkg::save_sz_t exp,
	input gba_loader_pkg::save_sz_t act);
	check_count++;
	if (act !== exp) begin
		err_count++;
		$display("FAIL time %0t save_sz expected %h actual %h", $time, exp, act);
	end
endtask

task automatic flag_check(input string name, input logic exp, input logic act);
	check_count++;
	if (act !== exp) begin
		err_count++;
		$display("FAIL time %0t %s expected %b actual %b", $time, name, exp, act);
	end
endtask

task automatic last_check(input logic [26:0] exp, input logic [26:0] act);
	check_count++;
	if (act !== exp) begin
		err_count++;
		$display("FAIL time %0t last_addr expected %h actual %h", $time, exp, act);
	end
endtask

`endif

/* dv/gba_loader_tb.sv */
// Loader testbench that streams BIOS and cartridge images and checks words, flags and save size
`timescale 1ns/1ps

module gba_loader_tb;

	localparam int  IOCTL_AW     = 27;
	localparam time CLK_PERIOD   = 100;
	localparam int  BIOS_HW      = 32;   // Halfwords per BIOS stream
	localparam int  CART_MAX_HW  = 128;  // Longest cartridge stream
	localparam int  WATCH_CYCLES = 2 * BIOS_HW + 3 * CART_MAX_HW + 400;  // Streams plus margin

	logic                        clk_sys;
	logic                        reset;
	logic                        ioctl_download;
	gba_loader_pkg::dl_index_t   ioctl_index;
	logic [IOCTL_AW-1:0]         ioctl_addr;
	gba_loader_pkg::ioctl_data_t ioctl_dout;
	logic                        ioctl_wr;
	logic                        save_eeprom;
	logic                        save_sram;
	logic                        save_flash;
	logic                        bus_req;
	logic                        img_mounted;
	logic                        img_readonly;
	gba_loader_pkg::img_size_t   img_size;
	gba_loader_pkg::bios_addr_t  bios_wraddr;
	gba_loader_pkg::bios_word_t  bios_wrdata;
	logic                        bios_wr;
	logic                        cart_active;
	logic                        flash_1m;
	logic [IOCTL_AW-1:0]         last_addr;
	logic                        sram_quirk;
	gba_loader_pkg::save_sz_t    save_sz;
	logic                        bk_ena;

	`include "gba_loader_ref.svh"

	gba_loader_pkg::bios_word_t exp_words [$];  // BIOS writes still to come
	gba_loader_pkg::bios_addr_t exp_addrs [$];
	logic                       exp_flash;
	logic                       exp_quirk;
	logic [IOCTL_AW-1:0]        exp_last;
	gba_loader_pkg::save_sz_t   exp_sz;
	logic                       img_in_use;     // Size is pinned by a mount
	int                         chk_kind;       // 0 reset, 1 cartridge, 2 save size, 3 streaming
	int                         test_num  = 0;
	int                         test_errs = 0;
	int unsigned                seed = 32'hafaa83e4;
	event                       check_req;
	event                       check_done;

	gba_loader_top #(.IOCTL_AW(IOCTL_AW), .BIOS_AW(12)) u_gba_loader_top (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// ======================================================================
	// Checker sampling at the falling edge where outputs are settled
	// ======================================================================
	initial begin
		forever begin
			@(check_req);
			@(negedge clk_sys);
			if (chk_kind == 3) begin
				flag_check("cart_active", 1'b1, cart_active);  // Cartridge class mid-transfer
			end else begin
				if (chk_kind == 0) begin
					flag_check("bios_wr", 1'b0, bios_wr);
					flag_check("cart_active", 1'b0, cart_active);
				end
				if (chk_kind != 2) begin
					flag_check("flash_1m", exp_flash, flash_1m);
					flag_check("sram_quirk", exp_quirk, sram_quirk);
				end
				if (chk_kind == 1) last_check(exp_last, last_addr);
				if (chk_kind != 1) begin
					size_check(exp_sz, save_sz);
					flag_check("bk_ena", |exp_sz, bk_ena);  // Backup present when size is nonzero
				end
			end
			-> check_done;
		end
	end

	// BIOS writes are matched in stream order
	always @(negedge clk_sys) begin
		if (!reset && bios_wr === 1'b1) begin
			if (exp_words.size() == 0) begin
				err_count++;
				$display("Unexpected BIOS write at time %0t", $time);
			end else begin
				bios_check(exp_addrs.pop_front(), exp_words.pop_front(),
					bios_wraddr, bios_wrdata);
			end
		end
	end

	task automatic request_check(input int kind);
		chk_kind = kind;
		-> check_req;
		@(check_done);
	endtask

	task automatic finish_test(input string name);
		test_num++;
		$display("Test %0d %s: %s", test_num, name, (err_count == test_errs) ? "passed" : "failed");
		test_errs = err_count;
	endtask

	task automatic send_bios_stream(input gba_loader_pkg::dl_index_t idx);
		logic [IOCTL_AW-1:0] base;
		logic [15:0]         hw;
		logic [15:0]         lo;
		base = IOCTL_AW'(($urandom % 255) * 64);  // Whole stream stays inside 16 KB
		@(posedge clk_sys);
		ioctl_index    <= idx;
		ioctl_download <= 1'b1;
		for (int i = 0; i < BIOS_HW; i++) begin
			hw = 16'($urandom);
			@(posedge clk_sys);
			ioctl_wr   <= 1'b1;
			ioctl_addr <= base + IOCTL_AW'(2 * i);
			ioctl_dout <= hw;
			if (i % 2 == 0) begin
				lo = hw;
			end else if (idx == 8'd0) begin
				exp_words.push_back(joined_word(lo, hw));
				exp_addrs.push_back(gba_loader_pkg::bios_addr_t'((base + 2 * i) >> 2));
			end
		end
		@(posedge clk_sys);
		ioctl_wr       <= 1'b0;
		ioctl_download <= 1'b0;
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic send_cart_image(input int sig_off, input logic quirk_title);
		gba_loader_pkg::cart_id_t title;
		int                       nhw;
		nhw = 96 + int'($urandom % 32);  // Always long enough to pass the title
		for (int i = 0; i < IMG_BYTES; i++) begin
			cart_img[i] = 8'($urandom);
		end
		for (int j = 0; j < 9 && sig_off >= 0; j++) begin
			cart_img[sig_off + j] = gba_loader_pkg::FLASH_SIG[71 - 8 * j -: 8];
		end
		if (quirk_title) begin
			title = gba_loader_pkg::QUIRK_IDS[$urandom % gba_loader_pkg::QUIRK_COUNT];
		end else begin
			for (int j = 0; j < 12; j++) begin
				title = {title[87:0], 8'h41 + 8'($urandom % 26)};
			end
		end
		for (int j = 0; j < 12; j++) begin
			cart_img[TITLE_BASE + j] = title[95 - 8 * j -: 8];
		end
		@(posedge clk_sys);
		ioctl_index    <= 8'($urandom_range(254, 1));
		ioctl_download <= 1'b1;
		for (int i = 0; i < nhw; i++) begin
			@(posedge clk_sys);
			ioctl_wr   <= 1'b1;
			ioctl_addr <= IOCTL_AW'(2 * i);
			ioctl_dout <= {cart_img[2 * i + 1], cart_img[2 * i]};  // Low byte first
		end
		request_check(3);  // Still inside the transfer
		@(posedge clk_sys);
		ioctl_wr       <= 1'b0;
		ioctl_download <= 1'b0;  // Address stays on the bus
		exp_flash  = expect_flash(2 * nhw);
		exp_quirk  = expect_quirk();
		exp_last   = IOCTL_AW'(2 * (nhw - 1));
		exp_sz     = '0;      // New cartridge starts without backup
		img_in_use = 1'b0;
		repeat (3) @(posedge clk_sys);
		request_check(1);
	endtask

	task automatic pulse_save_access(input logic ee, input logic sr, input logic fl);
		@(posedge clk_sys);
		save_eeprom <= ee;
		save_sram   <= sr;
		save_flash  <= fl;
		bus_req     <= 1'b1;
		@(posedge clk_sys);
		bus_req <= 1'b0;
		if (!img_in_use) exp_sz = grown_size(exp_sz, ee, sr, fl, exp_flash);
		@(posedge clk_sys);
		request_check(2);
	endtask

	task automatic mount_image(input gba_loader_pkg::img_size_t size, input logic ro);
		@(posedge clk_sys);
		img_mounted  <= 1'b1;
		img_readonly <= ro;
		img_size     <= size;
		@(posedge clk_sys);
		img_mounted <= 1'b0;
		if (size != '0 && !ro) begin
			img_in_use = 1'b1;
			exp_sz     = mounted_size(size);
		end
		@(posedge clk_sys);
		request_check(2);
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================
	initial begin
		void'($urandom(seed));
		reset          <= 1'b1;
		ioctl_download <= 1'b0;
		ioctl_index    <= 8'hFF;
		ioctl_addr     <= '0;
		ioctl_dout     <= '0;
		ioctl_wr       <= 1'b0;
		save_eeprom    <= 1'b0;
		save_sram      <= 1'b0;
		save_flash     <= 1'b0;
		bus_req        <= 1'b0;
		img_mounted    <= 1'b0;
		img_readonly   <= 1'b0;
		img_size       <= '0;
		exp_flash  = 1'b0;
		exp_quirk  = 1'b0;
		exp_sz     = '0;
		img_in_use = 1'b0;
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;
		request_check(0);
		finish_test("reset values");
		send_bios_stream(8'd0);
		if (exp_words.size() != 0) begin
			err_count++;
			$display("%0d BIOS writes never appeared", exp_words.size());
		end
		finish_test("BIOS packing");
		send_bios_stream(8'hFF);
		finish_test("index 255 gives no BIOS writes");
		send_cart_image('h40, 1'b1);
		finish_test("marker at even offset, quirk title");
		send_cart_image(-1, 1'b0);
		finish_test("no marker, random title");
		repeat (8) pulse_save_access(1'($urandom), 1'($urandom), 1'($urandom));
		finish_test("save size with 512 Kbit flash");
		send_cart_image('h51, 1'b1);
		finish_test("marker at odd offset, quirk title");
		repeat (6) pulse_save_access(1'($urandom), 1'($urandom), 1'($urandom));
		mount_image(64'h10000, 1'b1);         // Read-only image is ignored
		mount_image(64'h8000, 1'b0);          // 32 KB image takes over
		repeat (3) pulse_save_access(1'b1, 1'b1, 1'b1);
		finish_test("save size with 1 Mbit flash and image mount");
		$display("Tests %0d, checks %0d, errors %0d", test_num, check_count, err_count);
		if (err_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	initial begin
		#(WATCH_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the tests did not complete", WATCH_CYCLES);
		$display("Errors found");
		$finish;
	end

endmodule

/* rtl/gba_loader_top.sv */
// Cartridge loader top, decodes the download stream and feeds BIOS, scan, quirk and save blocks
`timescale 1ns/1ps

module gba_loader_top #(
	parameter int IOCTL_AW = 27,  // Host download address width
	parameter int BIOS_AW  = 12   // BIOS word address width
) (
	input  logic                        clk_sys,
	input  logic                        reset,
	// Host download stream
	input  logic                        ioctl_download,
	input  gba_loader_pkg::dl_index_t   ioctl_index,
	input  logic [IOCTL_AW-1:0]         ioctl_addr,
	input  gba_loader_pkg::ioctl_data_t ioctl_dout,
	input  logic                        ioctl_wr,
	// Core save-type reports
	input  logic                        save_eeprom,
	input  logic                        save_sram,
	input  logic                        save_flash,
	input  logic                        bus_req,
	// Backup image
	input  logic                        img_mounted,
	input  logic                        img_readonly,
	input  gba_loader_pkg::img_size_t   img_size,
	// Results
	output gba_loader_pkg::bios_addr_t  bios_wraddr,
	output gba_loader_pkg::bios_word_t  bios_wrdata,
	output logic                        bios_wr,
	output logic                        cart_active,
	output logic                        flash_1m,
	output logic [IOCTL_AW-1:0]         last_addr,
	output logic                        sram_quirk,
	output gba_loader_pkg::save_sz_t    save_sz,
	output logic                        bk_ena
);

	logic bios_active;
	logic cart_start;
	logic cart_end;

	// ======================================================================
	// Stream decode
	// ======================================================================
	download_decode u_download_decode (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.bios_active    (bios_active),
		.cart_active    (cart_active),
		.cart_start     (cart_start),
		.cart_end       (cart_end)
	);

	// ======================================================================
	// Execute blocks
	// ======================================================================
	bios_word_packer #(.BIOS_AW(BIOS_AW)) u_bios_word_packer (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.bios_active (bios_active),
		.ioctl_wr    (ioctl_wr),
		.ioctl_addr  (ioctl_addr[BIOS_AW+1:0]),  // BIOS fits in the low bits
		.ioctl_dout  (ioctl_dout),
		.bios_wraddr (bios_wraddr),
		.bios_wrdata (bios_wrdata),
		.bios_wr     (bios_wr)
	);

	cart_signature_scan #(.IOCTL_AW(IOCTL_AW)) u_cart_signature_scan (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cart_active (cart_active),
		.cart_start  (cart_start),
		.cart_end    (cart_end),
		.ioctl_wr    (ioctl_wr),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.flash_1m    (flash_1m),
		.last_addr   (last_addr)
	);

	cart_quirk_match #(.IOCTL_AW(IOCTL_AW)) u_cart_quirk_match (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cart_active (cart_active),
		.cart_start  (cart_start),
		.ioctl_wr    (ioctl_wr),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.sram_quirk  (sram_quirk)
	);

	// ======================================================================
	// Backup size result
	// ======================================================================
	save_size_tracker u_save_size_tracker (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cart_start   (cart_start),
		.flash_1m     (flash_1m),      // Flash size depends on the scan
		.save_eeprom  (save_eeprom),
		.save_sram    (save_sram),
		.save_flash   (save_flash),
		.bus_req      (bus_req),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size     (img_size),
		.save_sz      (save_sz),
		.bk_ena       (bk_ena)
	);

endmodule

/* rtl/save_size_tracker.sv */
// Save size tracker, sizes the backup memory from save-type accesses or a mounted image
`timescale 1ns/1ps

module save_size_tracker (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      cart_start,
	input  logic                      flash_1m,      // Selects 128 KB flash
	input  logic                      save_eeprom,
	input  logic                      save_sram,
	input  logic                      save_flash,
	input  logic                      bus_req,       // Core backup access strobe
	input  logic                      img_mounted,
	input  logic                      img_readonly,
	input  gba_loader_pkg::img_size_t img_size,
	output gba_loader_pkg::save_sz_t  save_sz,
	output logic                      bk_ena         // Backup present
);

	logic                     use_img;   // Size comes from the image, stop growing
	logic                     img_load;  // Usable image mounted this cycle
	gba_loader_pkg::save_sz_t sz_grow;   // Current size with all active masks

	assign img_load = img_mounted && (img_size != '0) && !img_readonly;

	always_comb begin
		sz_grow = save_sz;
		if (save_eeprom) sz_grow = sz_grow | gba_loader_pkg::SAVE_MASK_EEPROM;
		if (save_sram)   sz_grow = sz_grow | gba_loader_pkg::SAVE_MASK_SRAM;
		if (save_flash)  sz_grow = sz_grow | {flash_1m, gba_loader_pkg::SAVE_MASK_FLASH};
	end

	// ======================================================================
	// Size register, mount has the last word
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			save_sz <= '0;
			use_img <= 1'b0;
			bk_ena  <= 1'b0;
		end else begin
			if (cart_start) begin
				save_sz <= '0;
				use_img <= 1'b0;
			end
			if (bus_req && !use_img) save_sz <= sz_grow;
			if (img_load) begin
				use_img <= 1'b1;
				save_sz <= gba_loader_pkg::save_sz_t'(img_size[16:9] - 8'd1);  // Sectors minus one
			end
			bk_ena <= |save_sz;
		end
	end

	// Size only grows within one cartridge unless an image replaces it
	a_sz_grow: assert property (@(posedge clk_sys) disable iff (reset)
		(!cart_start && !img_load) |=> (($past(save_sz) & ~save_sz) == '0));

endmodule

/* cart_scan/cart_quirk_match.sv */
// Cartridge quirk match, compares the header title against titles that need SRAM
`timescale 1ns/1ps

module cart_quirk_match #(
	parameter int IOCTL_AW = 27  // Download byte address width
) (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        cart_active,
	input  logic                        cart_start,
	input  logic                        ioctl_wr,
	input  logic [IOCTL_AW-1:0]         ioctl_addr,
	input  gba_loader_pkg::ioctl_data_t ioctl_dout,
	output logic                        sram_quirk   // Title is in the quirk table
);

	gba_loader_pkg::cart_id_t cart_id;  // Title, first character in the top byte
	logic [3:0]  hdr_off;               // Byte offset inside the header line
	logic [6:0]  id_pos;                // Bit position of the halfword in cart_id
	logic        hdr_line;              // Write hits the title line
	logic        hdr_wr;
	logic        quirk_hit;
	logic [15:0] hw_swap;               // Halfword in title order

	assign hdr_off  = ioctl_addr[3:0];
	assign hdr_line = (ioctl_addr[IOCTL_AW-1:4] ==
		(IOCTL_AW-4)'(gba_loader_pkg::HDR_ID_LINE));
	assign hdr_wr   = cart_active & ioctl_wr & hdr_line;
	assign hw_swap  = {ioctl_dout[7:0], ioctl_dout[15:8]};  // Low byte comes first in the title

	// Offset 0 lands in the top 16 bits, offset 10 in the bottom 16
	assign id_pos = {4'd10 - hdr_off, 3'd0};

	// ======================================================================
	// Title capture
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (hdr_wr && (hdr_off < gba_loader_pkg::HDR_ID_END)) begin
			cart_id[id_pos +: 16] <= hw_swap;
		end
	end

	// ======================================================================
	// Table compare
	// ======================================================================
	always_comb begin
		quirk_hit = 1'b0;
		for (int i = 0; i < gba_loader_pkg::QUIRK_COUNT; i++) begin
			if (cart_id == gba_loader_pkg::QUIRK_IDS[i]) quirk_hit = 1'b1;
		end
	end

	// Decision at the first write past the title
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sram_quirk <= 1'b0;
		end else begin
			if (cart_start) sram_quirk <= 1'b0;
			if (hdr_wr && (hdr_off == gba_loader_pkg::HDR_ID_END) && quirk_hit) begin
				sram_quirk <= 1'b1;
			end
		end
	end

endmodule

/* cart_scan/cart_signature_scan.sv */
// Cartridge signature scan, detects the 1-Mbit flash marker and captures the image end
`timescale 1ns/1ps

module cart_signature_scan #(
	parameter int IOCTL_AW = 27  // Download byte address width
) (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        cart_active,
	input  logic                        cart_start,
	input  logic                        cart_end,
	input  logic                        ioctl_wr,
	input  logic [IOCTL_AW-1:0]         ioctl_addr,
	input  gba_loader_pkg::ioctl_data_t ioctl_dout,
	output logic                        flash_1m,    // Marker seen in this image
	output logic [IOCTL_AW-1:0]         last_addr    // Address held at the end of download
);

	logic [63:0] hist;      // Last 8 bytes, newest in the low byte
	logic [7:0]  byte_lo;   // First byte of the halfword
	logic [7:0]  byte_hi;   // Second byte
	logic        cart_wr;
	logic        match_lo;  // Marker ends on the low byte
	logic        match_hi;  // Marker ends on the high byte

	assign byte_lo = ioctl_dout[7:0];
	assign byte_hi = ioctl_dout[15:8];
	assign cart_wr = cart_active & ioctl_wr;

	// ======================================================================
	// Two alignments, the marker may start at an odd or even offset
	// ======================================================================
	assign match_lo = ({hist, byte_lo} == gba_loader_pkg::FLASH_SIG);
	assign match_hi = ({hist[55:0], byte_lo, byte_hi} == gba_loader_pkg::FLASH_SIG);

	// Byte history, little endian stream order
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			hist <= {hist[47:0], byte_lo, byte_hi};
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			flash_1m <= 1'b0;
		end else begin
			if (cart_start) flash_1m <= 1'b0;      // New image, forget the old one
			if (cart_wr && (match_lo || match_hi)) begin
				flash_1m <= 1'b1;                  // A hit in the first cycle still counts
			end
		end
	end

	// Host keeps the final address on the bus after download drops
	always_ff @(posedge clk_sys) begin
		if (cart_end) begin
			last_addr <= ioctl_addr;
		end
	end

endmodule

/* rtl/bios_word_packer.sv */
// BIOS packer, joins two download halfwords into one 32-bit BIOS write
`timescale 1ns/1ps

module bios_word_packer #(
	parameter int BIOS_AW = 12  // Word address width
) (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        bios_active,
	input  logic                        ioctl_wr,
	input  logic [BIOS_AW+1:0]          ioctl_addr,   // Byte address, only the BIOS range
	input  gba_loader_pkg::ioctl_data_t ioctl_dout,
	output gba_loader_pkg::bios_addr_t  bios_wraddr,
	output gba_loader_pkg::bios_word_t  bios_wrdata,
	output logic                        bios_wr       // One cycle per complete word
);

	logic bios_hw_wr;  // Halfword write inside a BIOS transfer

	assign bios_hw_wr = bios_active & ioctl_wr;

	// Write strobe, only the upper half completes a word
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bios_wr <= 1'b0;
		end else begin
			bios_wr <= bios_hw_wr & ioctl_addr[1];
		end
	end

	// Word data and address
	always_ff @(posedge clk_sys) begin
		if (bios_hw_wr) begin
			if (!ioctl_addr[1]) begin
				bios_wrdata[15:0] <= ioctl_dout;  // Lower half waits for its partner
			end else begin
				bios_wrdata[31:16] <= ioctl_dout;
				bios_wraddr        <= ioctl_addr[BIOS_AW+1:2];
			end
		end
	end

	// Host writes halfwords in pairs, so two words never arrive back to back
	a_wr_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		bios_wr |=> !bios_wr);

endmodule

/* rtl/download_decode.sv */
// Download decode, classifies the stream by index and marks cartridge start and end
`timescale 1ns/1ps

module download_decode (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      ioctl_download,  // High for the whole transfer
	input  gba_loader_pkg::dl_index_t ioctl_index,
	output logic                      bios_active,     // Index 0 transfer in progress
	output logic                      cart_active,     // Cartridge transfer in progress
	output logic                      cart_start,      // First cycle of cart_active
	output logic                      cart_end         // First cycle after cart_active
);

	logic cart_active_q;  // cart_active one cycle ago
	logic idx_bios;
	logic idx_cart;

	assign idx_bios = (ioctl_index == '0);
	assign idx_cart = (ioctl_index != '0) && (ioctl_index != '1);  // 255 is neither

	// ======================================================================
	// Class flags, one cycle behind the host
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bios_active   <= 1'b0;
			cart_active   <= 1'b0;
			cart_active_q <= 1'b0;
		end else begin
			bios_active   <= ioctl_download & idx_bios;
			cart_active   <= ioctl_download & idx_cart;
			cart_active_q <= cart_active;
		end
	end

	// Edge detect on the cartridge level
	assign cart_start = cart_active & ~cart_active_q;
	assign cart_end   = ~cart_active & cart_active_q;

	// The two classes come from disjoint index ranges
	a_class_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(bios_active && cart_active));

endmodule

/* common/gba_loader_pkg.sv */
// Loader package with the stream widths, the flash signature, save-size masks and quirk titles
package gba_loader_pkg;

	// ======================================================================
	// Vector types of the download stream and results
	// ======================================================================
	typedef logic [15:0] ioctl_data_t;  // One download halfword
	typedef logic [7:0]  dl_index_t;    // 0 BIOS, 1..254 cartridge, 255 neither
	typedef logic [11:0] bios_addr_t;   // BIOS word address, download bits 13:2
	typedef logic [31:0] bios_word_t;   // One packed BIOS word
	typedef logic [7:0]  save_sz_t;     // Save size in 512-byte sectors minus one
	typedef logic [95:0] cart_id_t;     // Header title, 12 ASCII bytes
	typedef logic [63:0] img_size_t;    // Mounted image size in bytes

	// ======================================================================
	// Cartridge detection constants
	// ======================================================================
	localparam logic [71:0] FLASH_SIG = "FLASH1M_V";  // 9-byte marker of the 1-Mbit flash

	// Save sizes are OR-ed together, so each mask is a power of two minus one
	localparam logic [7:0] SAVE_MASK_EEPROM = 8'h0F;  // 8 KB
	localparam logic [7:0] SAVE_MASK_SRAM   = 8'h3F;  // 32 KB
	localparam logic [6:0] SAVE_MASK_FLASH  = 7'h7F;  // 64 KB, flash_1m goes on top

	localparam logic [22:0] HDR_ID_LINE = 23'hA;  // Address bits 26:4 of the title line
	localparam logic [3:0]  HDR_ID_END  = 4'd12;  // Offset where the title is complete

	// ======================================================================
	// Titles that need SRAM instead of flash
	// ======================================================================
	localparam int QUIRK_COUNT = 18;

	// Short titles padded with zero bytes on the right
	localparam cart_id_t QUIRK_IDS [QUIRK_COUNT] = '{
		"ROCKY BOXING",                // Rocky, US
		{"ROCKY", 56'h0},              // Rocky, EU
		"DBZ LGCYGOKU",                // Legacy of Goku, US
		"DRAGONBALL Z",                // Legacy of Goku, EU
		"DBZ TAIKETSU",                // Taiketsu, US
		"DRAGON BALLZ",                // Taiketsu, EU
		{"TOPGUN CZ", 24'h0},
		{"BOMBER MAN", 16'h0},         // Classic NES series from here on
		{"CASTLEVANIA", 8'h0},
		{"DR. MARIO", 24'h0},
		{"EXCITEBIKE", 16'h0},
		{"ICE CLIMBER", 8'h0},
		{"NES METROID", 8'h0},
		{"PAC-MAN", 40'h0},
		{"SUPER MARIO", 8'h0},
		{"ZELDA 1", 40'h0},
		{"XEVIOUS", 40'h0},
		{"NES ZELDA 2", 8'h0}
	};

endpackage
